// File: Bender.yml
package:
  name: icache

sources:
  - files:
      - verilog/icache_pkg.sv
      - verilog/icache_tag_ram.sv
      - verilog/icache_data_ram.sv
      - verilog/icache_lru.sv
      - verilog/icache_fill.sv
      - verilog/icache_ctrl.sv
      - verilog/icache_top.sv
  - target: simulation
    files:
      - verif/icache_tb.sv

// File: filelist.f
verilog/icache_pkg.sv
verilog/icache_tag_ram.sv
verilog/icache_data_ram.sv
verilog/icache_lru.sv
verilog/icache_fill.sv
verilog/icache_ctrl.sv
verilog/icache_top.sv
verif/icache_tb.sv

// File: verif/icache_tb.sv
`timescale 1ns/1ps

module icache_tb;

    localparam int INDEX_W = 8;
    localparam int SETS    = 1 << INDEX_W;

    logic        clk_tmp = 1'b0;
    logic        rst;
    logic        flush;
    logic        fetch_req;
    logic [31:0] fetch_addr;
    logic [31:0] fetch_data;
    logic        fetch_valid;
    logic        miss_stall;
    logic        l2_busy;
    logic        l2_req;
    logic [31:0] l2_addr;
    logic        l2_rvalid;
    logic [31:0] l2_rdata;

    // reference cache, two ways
    logic [19:0] ref_tag [2][SETS];
    logic        ref_valid [2][SETS];
    logic        ref_lru [SETS];               // way to replace next

    // expected results in request order
    logic [31:0] exp_addr_q [$];
    logic [31:0] exp_data_q [$];
    bit          exp_miss_q [$];
    int          exp_cyc_q [$];
    logic [31:0] exp_l2_q [$];                 // line addresses of coming misses

    int          cycle = 0;
    int          issued = 0;
    int          err_cnt = 0;
    int          test_err = 0;
    int          pass_cnt = 0;
    int          fail_cnt = 0;
    int          miss_seen = 0;
    int          last_valid = 0;
    bit          busy_force = 1'b0;
    bit          prev_req = 1'b0;
    bit          prev_busy = 1'b0;
    bit          serving = 1'b0;
    int          beat = 0;
    logic [31:0] serve_addr;

    icache_top #(.INDEX_W(INDEX_W)) dut_i (
        .clk_tmp(clk_tmp), .rst(rst), .flush(flush),
        .fetch_req(fetch_req), .fetch_addr(fetch_addr),
        .fetch_data(fetch_data), .fetch_valid(fetch_valid), .miss_stall(miss_stall),
        .l2_busy(l2_busy), .l2_req(l2_req), .l2_addr(l2_addr),
        .l2_rvalid(l2_rvalid), .l2_rdata(l2_rdata)
    );

    always #5 clk_tmp = ~clk_tmp;

    always @(posedge clk_tmp) begin
        cycle <= cycle + 1;
        if (cycle > 40 * issued + 200) begin
            $display("timeout: DUT stopped responding after %0d cycles", cycle);
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic logic [31:0] l2_word(input logic [31:0] a);
        return {a[31:2], 2'b00} ^ 32'h5a5a0000;
    endfunction

    function automatic logic [31:0] make_addr(input logic [19:0] tag, input logic [7:0] idx,
                                              input logic [1:0] word);
        return {tag, idx, word, 2'b00};
    endfunction

    // L2 model, random busy and beat gaps
    always @(posedge clk_tmp) begin
        #1;
        l2_busy   = busy_force || ($urandom_range(3) == 0);
        l2_rvalid = 1'b0;
        if (!serving && l2_req) begin
            serving    = 1'b1;
            beat       = 0;
            serve_addr = l2_addr;
        end
        if (serving && $urandom_range(2) != 0) begin
            l2_rvalid = 1'b1;
            l2_rdata  = l2_word(serve_addr + 32'(4 * beat));  // lowest word first
            beat++;
            if (beat == 4) begin
                serving = 1'b0;
            end
        end
    end

    task automatic clear_model();
        for (int s = 0; s < SETS; s++) begin
            ref_valid[0][s] = 1'b0;
            ref_valid[1][s] = 1'b0;
            ref_lru[s]      = 1'b0;
        end
    endtask

    task automatic model_fetch(input logic [31:0] addr, output bit miss);
        logic [7:0]  idx;
        logic [19:0] tag;
        logic        way;
        idx  = addr[11:4];
        tag  = addr[31:12];
        miss = 1'b0;
        if (ref_valid[0][idx] && ref_tag[0][idx] == tag) begin
            way = 1'b0;
        end else if (ref_valid[1][idx] && ref_tag[1][idx] == tag) begin
            way = 1'b1;
        end else begin
            miss = 1'b1;
            way  = !ref_valid[0][idx] ? 1'b0 : !ref_valid[1][idx] ? 1'b1 : ref_lru[idx];
            ref_tag[way][idx]   = tag;
            ref_valid[way][idx] = 1'b1;
            exp_l2_q.push_back({addr[31:4], 4'h0});
        end
        ref_lru[idx] = ~way;                   // other way goes next
    endtask

    // called and returns 1 ns after a rising edge
    task automatic send_fetch(input logic [31:0] addr);
        bit miss;
        issued++;
        fetch_req  = 1'b1;
        fetch_addr = addr;
        while (miss_stall) begin
            @(posedge clk_tmp);
            #1;
        end
        @(posedge clk_tmp);                    // accepted on this edge
        #1;
        fetch_req = 1'b0;
        model_fetch(addr, miss);
        exp_addr_q.push_back(addr);
        exp_data_q.push_back(l2_word(addr));
        exp_miss_q.push_back(miss);
        exp_cyc_q.push_back(cycle);
    endtask

    task automatic drain();
        while (exp_data_q.size() != 0) begin
            @(posedge clk_tmp);
            #1;
        end
    endtask

    task automatic do_flush();
        drain();
        flush = 1'b1;
        @(posedge clk_tmp);
        #1;
        flush = 1'b0;
        clear_model();
    endtask

    task automatic check_result();
        logic [31:0] addr;
        logic [31:0] data;
        bit          miss;
        int          acc;
        int          due;
        assert (exp_data_q.size() > 0) else begin
            $display("fetch_valid came with no fetch outstanding at %0t", $time);
            err_cnt++;
        end
        if (exp_data_q.size() == 0) begin
            return;
        end
        addr = exp_addr_q.pop_front();
        data = exp_data_q.pop_front();
        miss = exp_miss_q.pop_front();
        acc  = exp_cyc_q.pop_front();
        due  = ((acc > last_valid) ? acc : last_valid) + 1;
        assert (fetch_data === data) else begin
            $display("error @%0t: data %h for %h, expected %h", $time, fetch_data, addr, data);
            err_cnt++;
        end
        assert (miss_seen == int'(miss)) else begin
            $display("error @%0t: %0d L2 requests for %h, expected miss=%0b", $time,
                     miss_seen, addr, miss);
            err_cnt++;
        end
        if (!miss) begin
            assert (cycle == due) else begin
                $display("error @%0t: hit on %h at cycle %0d, expected %0d", $time, addr,
                         cycle, due);
                err_cnt++;
            end
        end
        last_valid = cycle;
        miss_seen  = 0;
    endtask

    // outputs sampled at the falling edge
    always @(negedge clk_tmp) begin
        if (!rst) begin
            if (l2_req && !prev_req) begin
                assert (!prev_busy) else begin
                    $display("error @%0t: l2_req raised while l2_busy high", $time);
                    err_cnt++;
                end
                assert (exp_l2_q.size() > 0 && l2_addr === exp_l2_q[0]) else begin
                    $display("error @%0t: unexpected L2 request for %h", $time, l2_addr);
                    err_cnt++;
                end
                if (exp_l2_q.size() > 0) begin
                    void'(exp_l2_q.pop_front());
                end
                miss_seen++;
            end
            if (fetch_valid) begin
                check_result();
            end
        end
        prev_req  = l2_req;
        prev_busy = l2_busy;
    end

    task automatic end_test(input string name);
        drain();
        if (err_cnt == test_err) begin
            pass_cnt++;
            $display("test %s: ok", name);
        end else begin
            fail_cnt++;
            $display("test %s: %0d errors", name, err_cnt - test_err);
        end
        test_err = err_cnt;
    endtask

    initial begin
        logic [31:0] a;
        logic [19:0] tag_r;
        logic [7:0]  idx_r;
        logic [1:0]  word_r;
        void'($urandom(32'ha26b));
        rst        = 1'b1;
        flush      = 1'b0;
        fetch_req  = 1'b0;
        fetch_addr = '0;
        l2_busy    = 1'b0;
        l2_rvalid  = 1'b0;
        l2_rdata   = '0;
        clear_model();
        repeat (8) @(posedge clk_tmp);
        #1;
        rst = 1'b0;
        assert (!fetch_valid && !miss_stall && !l2_req) else begin
            $display("error @%0t: outputs not idle after reset", $time);
            err_cnt++;
        end

        a = make_addr(20'h00123, 8'h40, 2'd1);
        send_fetch(a);
        @(posedge clk_tmp);
        #1;
        assert (miss_stall) else begin
            $display("error @%0t: miss_stall low after cold miss", $time);
            err_cnt++;
        end
        drain();
        send_fetch(a);                         // must hit in one cycle
        end_test("cold_miss_hit");

        for (int w = 0; w < 4; w++) begin
            send_fetch(make_addr(20'h00123, 8'h40, 2'(w)));
        end
        end_test("word_select");

        // set 0x55, LRU points at tag 2 when tag 3 arrives
        send_fetch(make_addr(20'h00a01, 8'h55, 2'd0));
        send_fetch(make_addr(20'h00a02, 8'h55, 2'd1));
        send_fetch(make_addr(20'h00a01, 8'h55, 2'd2));
        send_fetch(make_addr(20'h00a03, 8'h55, 2'd3));
        send_fetch(make_addr(20'h00a01, 8'h55, 2'd0));
        send_fetch(make_addr(20'h00a02, 8'h55, 2'd1));
        end_test("replacement");

        do_flush();
        send_fetch(a);
        send_fetch(make_addr(20'h00a01, 8'h55, 2'd0));
        send_fetch(make_addr(20'h00a02, 8'h55, 2'd1));
        end_test("flush");

        @(negedge clk_tmp);
        busy_force = 1'b1;
        @(posedge clk_tmp);
        #1;
        send_fetch(make_addr(20'h00777, 8'h21, 2'd2));
        repeat (20) @(posedge clk_tmp);
        #1;
        assert (miss_stall && !l2_req) else begin
            $display("error @%0t: miss went ahead while L2 busy", $time);
            err_cnt++;
        end
        @(negedge clk_tmp);
        busy_force = 1'b0;
        @(posedge clk_tmp);
        #1;
        end_test("busy_backpressure");

        for (int n = 0; n < 500; n++) begin
            if ($urandom_range(39) == 0) begin
                do_flush();
            end
            tag_r  = 20'h00200 + 20'($urandom_range(3));   // small pool, forces conflicts
            idx_r  = 8'h30 + 8'($urandom_range(3));
            word_r = 2'($urandom_range(3));
            send_fetch(make_addr(tag_r, idx_r, word_r));
            if ($urandom_range(1) == 0) begin
                repeat ($urandom_range(3)) begin
                    @(posedge clk_tmp);
                    #1;
                end
            end
        end
        end_test("random_stream");

        $display("tests passed: %0d, tests failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: verilog/icache_ctrl.sv
`timescale 1ns/1ps

module icache_ctrl import icache_pkg::*; #(
    parameter int INDEX_W = 8
) (
    input  logic                                  clk_tmp,
    input  logic                                  rst,
    input  logic                                  fetch_req,
    input  logic [ADDR_W-1:0]                     fetch_addr,
    output logic [WORD_W-1:0]                     fetch_data,
    output logic                                  fetch_valid,
    output logic                                  miss_stall,
    output logic [INDEX_W-1:0]                    lookup_index,
    input  logic [ADDR_W-INDEX_W-OFFSET_W-1:0]    tag0,
    input  logic [ADDR_W-INDEX_W-OFFSET_W-1:0]    tag1,
    input  logic                                  valid0,
    input  logic                                  valid1,
    input  logic [LINE_W-1:0]                     line0,
    input  logic [LINE_W-1:0]                     line1,
    input  logic                                  victim_way,
    output logic                                  hit_en,
    output logic                                  hit_way,
    input  logic                                  l2_busy,
    output logic                                  fill_start,
    output logic [ADDR_W-1:0]                     fill_addr,
    output logic                                  fill_way,
    input  logic                                  fill_done
);

    localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W;

    ic_state_e          state;
    logic [ADDR_W-1:0]  req_addr;              // address under lookup
    logic [ADDR_W-1:0]  pend_addr;             // accepted on the miss edge
    logic               pend_valid;
    logic [TAG_W-1:0]   req_tag;
    logic [1:0]         word_sel;
    logic               hit0;
    logic               hit1;
    logic               hit;
    logic [LINE_W-1:0]  hit_line;
    logic [WORD_W-1:0]  hit_word;
    logic               accept;
    logic               lookup_hit;
    logic               lookup_miss;
    logic               load_req;
    logic [ADDR_W-1:0]  next_req;

    assign req_tag      = req_addr[ADDR_W-1 -: TAG_W];
    assign word_sel     = req_addr[OFFSET_W-1:2];
    assign lookup_index = req_addr[OFFSET_W +: INDEX_W];

    // two-way compare
    assign hit0     = valid0 && (tag0 == req_tag);
    assign hit1     = valid1 && (tag1 == req_tag);
    assign hit      = hit0 || hit1;
    assign hit_line = hit0 ? line0 : line1;
    assign hit_word = hit_line[word_sel*WORD_W +: WORD_W];

    assign accept      = fetch_req && !miss_stall;
    assign lookup_hit  = (state == IC_LOOKUP) && hit;
    assign lookup_miss = (state == IC_LOOKUP) && !hit;

    // LRU touch on normal hit and on the re-read after refill
    assign hit_en  = hit && (state == IC_LOOKUP || state == IC_RESUME);
    assign hit_way = !hit0;

    // start only once L2 is free
    assign fill_start = (state == IC_WAIT_BUSY) && !l2_busy;
    assign fill_addr  = req_addr;              // held through the whole miss

    // next address into lookup
    assign load_req = (state == IC_IDLE && accept) ||
                      (lookup_hit && accept) ||
                      (state == IC_RESUME && pend_valid);
    assign next_req = (state == IC_RESUME) ? pend_addr : fetch_addr;

    always_ff @(posedge clk_tmp) begin
        if (rst) begin
            state       <= IC_IDLE;
            fetch_valid <= 1'b0;
            miss_stall  <= 1'b0;
            pend_valid  <= 1'b0;
            fill_way    <= 1'b0;
        end else begin
            fetch_valid <= 1'b0;
            case (state)
                IC_IDLE: begin
                    if (accept) begin
                        state <= IC_LOOKUP;
                    end
                end
                IC_LOOKUP: begin
                    if (hit) begin
                        fetch_valid <= 1'b1;
                        if (!accept) begin
                            state <= IC_IDLE;
                        end
                    end else begin
                        miss_stall <= 1'b1;
                        fill_way   <= victim_way;     // victim frozen for the fill
                        pend_valid <= accept;
                        state      <= IC_WAIT_BUSY;
                    end
                end
                IC_WAIT_BUSY: begin
                    if (!l2_busy) begin
                        state <= IC_REFILL;
                    end
                end
                IC_REFILL: begin
                    if (fill_done) begin
                        state <= IC_RESUME;
                    end
                end
                IC_RESUME: begin
                    fetch_valid <= 1'b1;
                    miss_stall  <= 1'b0;
                    pend_valid  <= 1'b0;
                    state       <= pend_valid ? IC_LOOKUP : IC_IDLE;
                end
                default: state <= IC_IDLE;
            endcase
        end
    end

    // address and data registers
    always_ff @(posedge clk_tmp) begin
        if (load_req) begin
            req_addr <= next_req;
        end
        if (lookup_miss && accept) begin
            pend_addr <= fetch_addr;
        end
        if (lookup_hit || state == IC_RESUME) begin
            fetch_data <= hit_word;
        end
    end

endmodule

// File: verilog/icache_data_ram.sv
`timescale 1ns/1ps

module icache_data_ram import icache_pkg::*; #(
    parameter int INDEX_W = 8
) (
    input  logic               clk_tmp,
    input  logic [INDEX_W-1:0] rd_index,
    output logic [LINE_W-1:0]  rd_line,
    input  logic               we,
    input  logic [INDEX_W-1:0] wr_index,
    input  logic [LINE_W-1:0]  wr_line
);

    localparam int SETS = 1 << INDEX_W;

    logic [LINE_W-1:0] line_mem [SETS];        // contents only trusted when valid

    assign rd_line = line_mem[rd_index];       // async read for single cycle hit

    always_ff @(posedge clk_tmp) begin
        if (we) begin
            line_mem[wr_index] <= wr_line;     // whole line at once
        end
    end

endmodule

// File: verilog/icache_fill.sv
`timescale 1ns/1ps

module icache_fill import icache_pkg::*; #(
    parameter int INDEX_W = 8
) (
    input  logic                                  clk_tmp,
    input  logic                                  rst,
    input  logic                                  fill_start,
    input  logic [ADDR_W-1:0]                     fill_addr,
    input  logic                                  fill_way,
    output logic                                  fill_done,
    output logic                                  l2_req,
    output logic [ADDR_W-1:0]                     l2_addr,
    input  logic                                  l2_rvalid,
    input  logic [WORD_W-1:0]                     l2_rdata,
    output logic                                  we0,
    output logic                                  we1,
    output logic [INDEX_W-1:0]                    wr_index,
    output logic [ADDR_W-INDEX_W-OFFSET_W-1:0]    wr_tag,
    output logic [LINE_W-1:0]                     wr_line
);

    localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W;

    fill_state_e      state;
    logic [1:0]       beat_cnt;                // beats already taken
    logic             way_q;
    logic [LINE_W-1:0] line_q;
    logic             writing;

    assign writing   = (state == FILL_WRITE);
    assign fill_done = writing;                // same cycle as the array write
    assign we0       = writing && !way_q;
    assign we1       = writing && way_q;
    assign wr_index  = l2_addr[OFFSET_W +: INDEX_W];
    assign wr_tag    = l2_addr[ADDR_W-1 -: TAG_W];
    assign wr_line   = line_q;

    always_ff @(posedge clk_tmp) begin
        if (rst) begin
            state    <= FILL_IDLE;
            l2_req   <= 1'b0;
            beat_cnt <= '0;
        end else begin
            case (state)
                FILL_IDLE: begin
                    if (fill_start) begin
                        l2_req   <= 1'b1;
                        beat_cnt <= '0;
                        state    <= FILL_BEATS;
                    end
                end
                FILL_BEATS: begin
                    if (l2_rvalid) begin
                        l2_req   <= 1'b0;      // held only until first beat
                        beat_cnt <= beat_cnt + 2'd1;
                        if (beat_cnt == 2'd3) begin
                            state <= FILL_WRITE;
                        end
                    end
                end
                FILL_WRITE: state <= FILL_IDLE;
                default:    state <= FILL_IDLE;
            endcase
        end
    end

    // request address, way and line data
    always_ff @(posedge clk_tmp) begin
        if (state == FILL_IDLE && fill_start) begin
            l2_addr <= {fill_addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
            way_q   <= fill_way;
        end
        if (state == FILL_BEATS && l2_rvalid) begin
            line_q <= {l2_rdata, line_q[LINE_W-1:WORD_W]};  // word 0 ends at bottom
        end
    end

endmodule

// File: verilog/icache_lru.sv
`timescale 1ns/1ps

module icache_lru #(
    parameter int INDEX_W = 8
) (
    input  logic               clk_tmp,
    input  logic               rst,
    input  logic               flush,
    input  logic [INDEX_W-1:0] index,
    input  logic               valid0,
    input  logic               valid1,
    output logic               victim_way,
    input  logic               hit_en,
    input  logic               hit_way,
    input  logic               fill_we,
    input  logic               fill_way,
    input  logic [INDEX_W-1:0] fill_index
);

    localparam int SETS = 1 << INDEX_W;

    logic [SETS-1:0] lru_q;                    // way to replace next

    // empty ways first, then the stored choice
    assign victim_way = !valid0 ? 1'b0 :
                        !valid1 ? 1'b1 : lru_q[index];

    always_ff @(posedge clk_tmp) begin
        if (rst || flush) begin
            lru_q <= '0;
        end else begin
            if (hit_en) begin
                lru_q[index] <= ~hit_way;      // point away from used way
            end
            if (fill_we) begin
                lru_q[fill_index] <= ~fill_way;
            end
        end
    end

endmodule

// File: verilog/icache_pkg.sv
package icache_pkg;

    // fetch side widths
    parameter int ADDR_W   = 32;
    parameter int WORD_W   = 32;

    // line geometry
    parameter int LINE_W   = 128;              // four words per line
    parameter int OFFSET_W = 4;                // byte offset, bits 3:2 pick the word

    // lookup and miss sequencing
    typedef enum logic [2:0] {
        IC_IDLE      = 3'd0,                   // nothing under lookup
        IC_LOOKUP    = 3'd1,                   // tag compare on held address
        IC_WAIT_BUSY = 3'd2,                   // miss, L2 still busy
        IC_REFILL    = 3'd3,                   // fill unit owns L2
        IC_RESUME    = 3'd4                    // re-read refilled line
    } ic_state_e;

    // line collection from L2
    typedef enum logic [1:0] {
        FILL_IDLE  = 2'd0,
        FILL_BEATS = 2'd1,                     // request out, beats arriving
        FILL_WRITE = 2'd2                      // one cycle array write
    } fill_state_e;

endpackage

// File: verilog/icache_tag_ram.sv
`timescale 1ns/1ps

module icache_tag_ram import icache_pkg::*; #(
    parameter int INDEX_W = 8
) (
    input  logic                                  clk_tmp,
    input  logic                                  rst,
    input  logic                                  flush,
    input  logic [INDEX_W-1:0]                    rd_index,
    output logic [ADDR_W-INDEX_W-OFFSET_W-1:0]    rd_tag,
    output logic                                  rd_valid,
    input  logic                                  we,
    input  logic [INDEX_W-1:0]                    wr_index,
    input  logic [ADDR_W-INDEX_W-OFFSET_W-1:0]    wr_tag
);

    localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W;
    localparam int SETS  = 1 << INDEX_W;

    logic [TAG_W-1:0] tag_mem [SETS];          // one tag per set
    logic [SETS-1:0]  valid_q;

    // lookup happens in the same cycle as the address
    assign rd_tag   = tag_mem[rd_index];
    assign rd_valid = valid_q[rd_index];

    always_ff @(posedge clk_tmp) begin
        if (we) begin
            tag_mem[wr_index] <= wr_tag;
        end
    end

    // flush wins over a write to the same set
    always_ff @(posedge clk_tmp) begin
        if (rst || flush) begin
            valid_q <= '0;
        end else if (we) begin
            valid_q[wr_index] <= 1'b1;
        end
    end

endmodule

// File: verilog/icache_top.sv
`timescale 1ns/1ps

module icache_top import icache_pkg::*; #(
    parameter int INDEX_W = 8
) (
    input  logic              clk_tmp,
    input  logic              rst,
    input  logic              flush,
    input  logic              fetch_req,
    input  logic [ADDR_W-1:0] fetch_addr,
    output logic [WORD_W-1:0] fetch_data,
    output logic              fetch_valid,
    output logic              miss_stall,
    input  logic              l2_busy,
    output logic              l2_req,
    output logic [ADDR_W-1:0] l2_addr,
    input  logic              l2_rvalid,
    input  logic [WORD_W-1:0] l2_rdata
);

    localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W;

    // lookup path
    logic [INDEX_W-1:0] lookup_index;
    logic [TAG_W-1:0]   tag0;
    logic [TAG_W-1:0]   tag1;
    logic               valid0;
    logic               valid1;
    logic [LINE_W-1:0]  line0;
    logic [LINE_W-1:0]  line1;
    logic               victim_way;
    logic               hit_en;
    logic               hit_way;

    // refill path
    logic               fill_start;
    logic [ADDR_W-1:0]  fill_addr;
    logic               fill_way;
    logic               fill_done;
    logic               we0;
    logic               we1;
    logic [INDEX_W-1:0] wr_index;
    logic [TAG_W-1:0]   wr_tag;
    logic [LINE_W-1:0]  wr_line;

    icache_ctrl #(.INDEX_W(INDEX_W)) ctrl_i (
        .clk_tmp(clk_tmp), .rst(rst),
        .fetch_req(fetch_req), .fetch_addr(fetch_addr),
        .fetch_data(fetch_data), .fetch_valid(fetch_valid), .miss_stall(miss_stall),
        .lookup_index(lookup_index),
        .tag0(tag0), .tag1(tag1), .valid0(valid0), .valid1(valid1),
        .line0(line0), .line1(line1),
        .victim_way(victim_way), .hit_en(hit_en), .hit_way(hit_way),
        .l2_busy(l2_busy),
        .fill_start(fill_start), .fill_addr(fill_addr), .fill_way(fill_way),
        .fill_done(fill_done)
    );

    icache_fill #(.INDEX_W(INDEX_W)) fill_i (
        .clk_tmp(clk_tmp), .rst(rst),
        .fill_start(fill_start), .fill_addr(fill_addr), .fill_way(fill_way),
        .fill_done(fill_done),
        .l2_req(l2_req), .l2_addr(l2_addr), .l2_rvalid(l2_rvalid), .l2_rdata(l2_rdata),
        .we0(we0), .we1(we1),
        .wr_index(wr_index), .wr_tag(wr_tag), .wr_line(wr_line)
    );

    // fill_done marks the array write cycle
    icache_lru #(.INDEX_W(INDEX_W)) lru_i (
        .clk_tmp(clk_tmp), .rst(rst), .flush(flush),
        .index(lookup_index), .valid0(valid0), .valid1(valid1),
        .victim_way(victim_way),
        .hit_en(hit_en), .hit_way(hit_way),
        .fill_we(fill_done), .fill_way(fill_way), .fill_index(wr_index)
    );

    icache_tag_ram #(.INDEX_W(INDEX_W)) way0_tag_i (
        .clk_tmp(clk_tmp), .rst(rst), .flush(flush),
        .rd_index(lookup_index), .rd_tag(tag0), .rd_valid(valid0),
        .we(we0), .wr_index(wr_index), .wr_tag(wr_tag)
    );

    icache_tag_ram #(.INDEX_W(INDEX_W)) way1_tag_i (
        .clk_tmp(clk_tmp), .rst(rst), .flush(flush),
        .rd_index(lookup_index), .rd_tag(tag1), .rd_valid(valid1),
        .we(we1), .wr_index(wr_index), .wr_tag(wr_tag)
    );

    icache_data_ram #(.INDEX_W(INDEX_W)) way0_data_i (
        .clk_tmp(clk_tmp),
        .rd_index(lookup_index), .rd_line(line0),
        .we(we0), .wr_index(wr_index), .wr_line(wr_line)
    );

    icache_data_ram #(.INDEX_W(INDEX_W)) way1_data_i (
        .clk_tmp(clk_tmp),
        .rd_index(lookup_index), .rd_line(line1),
        .we(we1), .wr_index(wr_index), .wr_line(wr_line)
    );

endmodule
